//--- fetch_pkg.sv
package fetch_pkg;

  // Address and instruction width
  localparam int XLEN    = 32;
  localparam int ORDER_W = 32;

  // Branch era carried on the bus tag lines
  localparam int ERA_W = 4;

  localparam int DEPTH_DEFAULT       = 8;
  localparam int BTB_ENTRIES_DEFAULT = 16;

  // Major opcodes recognised by the pre-decode
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  typedef enum logic [2:0] {
    CLS_OTHER  = 3'd0,
    CLS_BRANCH = 3'd1,
    CLS_JAL    = 3'd2,
    CLS_JALR   = 3'd3,
    CLS_LOAD   = 3'd4,
    CLS_STORE  = 3'd5
  } opcode_class_e;

endpackage

//--- fetch_req_if.sv
`timescale 1ns/1ps

interface fetch_req_if;

  // Metadata write, one per accepted bus request
  logic                          wr;
  logic [fetch_pkg::XLEN-1:0]    pc;
  logic [fetch_pkg::ORDER_W-1:0] order;
  logic                          pred_taken;
  logic [fetch_pkg::XLEN-1:0]    pred_next;

  // Instruction word from an era-matching bus response
  logic                          dwr;
  logic [fetch_pkg::XLEN-1:0]    ddata;

  logic                          flush;
  logic                          full;

  modport seq (
    output wr, pc, order, pred_taken, pred_next, dwr, ddata, flush,
    input  full
  );

  modport queue (
    input  wr, pc, order, pred_taken, pred_next, dwr, ddata, flush,
    output full
  );

endinterface

//--- fetch_issue_if.sv
`timescale 1ns/1ps

interface fetch_issue_if;

  // Head entry, valid while ready is high
  logic                          ready;
  logic [fetch_pkg::XLEN-1:0]    pc;
  logic [fetch_pkg::ORDER_W-1:0] order;
  logic                          pred_taken;
  logic [fetch_pkg::XLEN-1:0]    pred_next;
  logic [fetch_pkg::XLEN-1:0]    data;

  // Advances the head at the clock edge
  logic                          pop;

  modport queue (
    output ready, pc, order, pred_taken, pred_next, data,
    input  pop
  );

  modport issue (
    input  ready, pc, order, pred_taken, pred_next, data,
    output pop
  );

endinterface

//--- fetch_btb.sv
`timescale 1ns/1ps

module fetch_btb #(
  parameter int BTB_ENTRIES = fetch_pkg::BTB_ENTRIES_DEFAULT
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [fetch_pkg::XLEN-1:0] lookup_pc_i,
  input  logic                       upd_i,
  input  logic [fetch_pkg::XLEN-1:0] upd_pc_i,
  input  logic [fetch_pkg::XLEN-1:0] upd_target_i,
  input  logic                       upd_taken_i,
  output logic                       hit_o,
  output logic [fetch_pkg::XLEN-1:0] target_o
);

  localparam int IW = $clog2(BTB_ENTRIES);
  localparam int TW = fetch_pkg::XLEN - 2 - IW;

  logic [BTB_ENTRIES-1:0]       valid_q;
  logic [TW-1:0]                tag_mem    [BTB_ENTRIES];
  logic [fetch_pkg::XLEN-1:0]   target_mem [BTB_ENTRIES];
  logic [IW-1:0]                rd_idx;
  logic [IW-1:0]                wr_idx;

  // Word address bits select the entry, the rest form the tag
  assign rd_idx = lookup_pc_i[2 +: IW];
  assign wr_idx = upd_pc_i[2 +: IW];

  assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == lookup_pc_i[fetch_pkg::XLEN-1 -: TW]);
  assign target_o = target_mem[rd_idx];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      valid_q <= '0;
    end
    else if (upd_i)
    begin
      // A not-taken miss invalidates the entry
      valid_q[wr_idx] <= upd_taken_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (upd_i)
    begin
      tag_mem[wr_idx]    <= upd_pc_i[fetch_pkg::XLEN-1 -: TW];
      target_mem[wr_idx] <= upd_target_i;
    end
  end

endmodule

//--- fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer (
  input  logic                          clk_i,
  input  logic                          rst_i,

  // Redirect from execute
  input  logic                          br_miss_i,
  input  logic [fetch_pkg::XLEN-1:0]    miss_pc_i,
  input  logic [fetch_pkg::ORDER_W-1:0] miss_order_i,

  // Instruction bus
  input  logic                          bus_stall_i,
  input  logic                          bus_ack_i,
  input  logic [fetch_pkg::ERA_W-1:0]   bus_tgc_i,
  input  logic [fetch_pkg::XLEN-1:0]    bus_data_i,
  output logic [fetch_pkg::XLEN-1:0]    bus_adr_o,
  output logic                          bus_stb_o,
  output logic [fetch_pkg::ERA_W-1:0]   bus_tgc_o,

  // BTB lookup
  output logic [fetch_pkg::XLEN-1:0]    fetch_pc_o,
  input  logic                          pred_hit_i,
  input  logic [fetch_pkg::XLEN-1:0]    pred_target_i,

  fetch_req_if.seq                      req
);

  logic [fetch_pkg::XLEN-1:0]    pc_q;
  logic [fetch_pkg::ORDER_W-1:0] order_q;
  logic [fetch_pkg::ERA_W-1:0]   era_q;
  logic [fetch_pkg::XLEN-1:0]    pred_next;
  logic                          accept;

  assign pred_next = pred_hit_i ? pred_target_i : pc_q + fetch_pkg::XLEN'(4);

  // Request whenever the queue has a free slot
  assign bus_stb_o = ~req.full & ~rst_i;
  assign accept    = bus_stb_o & ~bus_stall_i;

  assign bus_adr_o  = pc_q;
  assign bus_tgc_o  = era_q;
  assign fetch_pc_o = pc_q;

  // Metadata goes into the queue at the accepting edge
  assign req.wr         = accept;
  assign req.pc         = pc_q;
  assign req.order      = order_q;
  assign req.pred_taken = pred_hit_i;
  assign req.pred_next  = pred_next;

  // Responses tagged with an older era belong to a squashed path
  assign req.dwr   = bus_ack_i & (bus_tgc_i == era_q);
  assign req.ddata = bus_data_i;

  assign req.flush = br_miss_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      pc_q    <= '0;
      order_q <= '0;
      era_q   <= '0;
    end
    else if (br_miss_i)
    begin
      // A request accepted at this edge is dropped with the flush
      pc_q    <= miss_pc_i;
      order_q <= miss_order_i;
      era_q   <= era_q + 1'b1;
    end
    else if (accept)
    begin
      pc_q    <= pred_next;
      order_q <= order_q + 1'b1;
    end
  end

endmodule

//--- fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
  parameter int DEPTH = fetch_pkg::DEPTH_DEFAULT
) (
  input  logic          clk_i,
  input  logic          rst_i,
  fetch_req_if.queue    req,
  fetch_issue_if.queue  head
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [fetch_pkg::XLEN-1:0]    pc_mem    [DEPTH];
  logic [fetch_pkg::ORDER_W-1:0] order_mem [DEPTH];
  logic                          taken_mem [DEPTH];
  logic [fetch_pkg::XLEN-1:0]    pnext_mem [DEPTH];
  logic [fetch_pkg::XLEN-1:0]    data_mem  [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] dwr_ptr;
  logic [AW-1:0] rd_ptr;

  // Entries holding metadata, and entries holding metadata and data
  logic [CW-1:0] count;
  logic [CW-1:0] dcount;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1))
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign req.full   = (count == CW'(DEPTH));
  assign head.ready = (dcount != '0);

  // First-word fall-through head
  assign head.pc         = pc_mem[rd_ptr];
  assign head.order      = order_mem[rd_ptr];
  assign head.pred_taken = taken_mem[rd_ptr];
  assign head.pred_next  = pnext_mem[rd_ptr];
  assign head.data       = data_mem[rd_ptr];

  always_ff @(posedge clk_i)
  begin
    if (rst_i || req.flush)
    begin
      wr_ptr  <= '0;
      dwr_ptr <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      dcount  <= '0;
    end
    else
    begin
      if (req.wr)
        wr_ptr <= next_ptr(wr_ptr);
      if (req.dwr)
        dwr_ptr <= next_ptr(dwr_ptr);
      if (head.pop)
        rd_ptr <= next_ptr(rd_ptr);
      count  <= count + CW'(req.wr) - CW'(head.pop);
      dcount <= dcount + CW'(req.dwr) - CW'(head.pop);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req.wr)
    begin
      pc_mem[wr_ptr]    <= req.pc;
      order_mem[wr_ptr] <= req.order;
      taken_mem[wr_ptr] <= req.pred_taken;
      pnext_mem[wr_ptr] <= req.pred_next;
    end
    if (req.dwr)
      data_mem[dwr_ptr] <= req.ddata;
  end

endmodule

//--- fetch_issue.sv
`timescale 1ns/1ps

module fetch_issue (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          freeze_i,
  input  logic                          br_miss_i,

  fetch_issue_if.issue                  head,

  output logic                          vld_o,
  output logic [fetch_pkg::XLEN-1:0]    inst_o,
  output logic [fetch_pkg::XLEN-1:0]    pc_o,
  output logic [fetch_pkg::ORDER_W-1:0] order_o,
  output logic                          br_taken_o,
  output logic [fetch_pkg::XLEN-1:0]    pred_next_o,
  output fetch_pkg::opcode_class_e      class_o
);

  // Pre-decode on the major opcode
  function automatic fetch_pkg::opcode_class_e classify(input logic [6:0] opc);
    case (opc)
      fetch_pkg::OPC_BRANCH: return fetch_pkg::CLS_BRANCH;
      fetch_pkg::OPC_JAL:    return fetch_pkg::CLS_JAL;
      fetch_pkg::OPC_JALR:   return fetch_pkg::CLS_JALR;
      fetch_pkg::OPC_LOAD:   return fetch_pkg::CLS_LOAD;
      fetch_pkg::OPC_STORE:  return fetch_pkg::CLS_STORE;
      default:               return fetch_pkg::CLS_OTHER;
    endcase
  endfunction

  assign head.pop = head.ready & ~freeze_i & ~br_miss_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      vld_o <= 1'b0;
    end
    else if (br_miss_i)
    begin
      vld_o <= 1'b0;
    end
    else if (!freeze_i)
    begin
      vld_o <= head.pop;
    end
  end

  // Payload only moves on a pop, so freeze and miss leave it alone
  always_ff @(posedge clk_i)
  begin
    if (head.pop)
    begin
      inst_o      <= head.data;
      pc_o        <= head.pc;
      order_o     <= head.order;
      br_taken_o  <= head.pred_taken;
      pred_next_o <= head.pred_next;
      class_o     <= classify(head.data[6:0]);
    end
  end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter int DEPTH       = fetch_pkg::DEPTH_DEFAULT,
  parameter int BTB_ENTRIES = fetch_pkg::BTB_ENTRIES_DEFAULT
) (
  input  logic                          clk,
  input  logic                          rst,

  input  logic                          exu_br_miss_i,
  input  logic [fetch_pkg::XLEN-1:0]    exu_br_pc_i,
  input  logic                          exu_br_taken_i,
  input  logic [fetch_pkg::XLEN-1:0]    exu_pc_next_i,
  input  logic [fetch_pkg::ORDER_W-1:0] exu_order_next_i,
  input  logic                          exu_freeze_i,

  output logic [fetch_pkg::XLEN-1:0]    bus_adr_o,
  output logic                          bus_stb_o,
  output logic [fetch_pkg::ERA_W-1:0]   bus_tgc_o,
  input  logic                          bus_stall_i,
  input  logic                          bus_ack_i,
  input  logic [fetch_pkg::XLEN-1:0]    bus_data_i,
  input  logic [fetch_pkg::ERA_W-1:0]   bus_tgc_i,

  output logic                          ifu_vld_o,
  output logic [fetch_pkg::XLEN-1:0]    ifu_inst_o,
  output logic [fetch_pkg::XLEN-1:0]    ifu_pc_o,
  output logic [fetch_pkg::ORDER_W-1:0] ifu_order_o,
  output logic                          ifu_br_taken_o,
  output logic [fetch_pkg::XLEN-1:0]    ifu_pred_next_o,
  output fetch_pkg::opcode_class_e      ifu_class_o
);

  logic [fetch_pkg::XLEN-1:0] fetch_pc;
  logic                       pred_hit;
  logic [fetch_pkg::XLEN-1:0] pred_target;

  fetch_req_if   req_if ();
  fetch_issue_if head_if ();

  fetch_btb #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) fetch_btb_i (
    .clk_i        (clk),
    .rst_i        (rst),
    .lookup_pc_i  (fetch_pc),
    .upd_i        (exu_br_miss_i),
    .upd_pc_i     (exu_br_pc_i),
    .upd_target_i (exu_pc_next_i),
    .upd_taken_i  (exu_br_taken_i),
    .hit_o        (pred_hit),
    .target_o     (pred_target)
  );

  fetch_sequencer fetch_sequencer_i (
    .clk_i         (clk),
    .rst_i         (rst),
    .br_miss_i     (exu_br_miss_i),
    .miss_pc_i     (exu_pc_next_i),
    .miss_order_i  (exu_order_next_i),
    .bus_stall_i   (bus_stall_i),
    .bus_ack_i     (bus_ack_i),
    .bus_tgc_i     (bus_tgc_i),
    .bus_data_i    (bus_data_i),
    .bus_adr_o     (bus_adr_o),
    .bus_stb_o     (bus_stb_o),
    .bus_tgc_o     (bus_tgc_o),
    .fetch_pc_o    (fetch_pc),
    .pred_hit_i    (pred_hit),
    .pred_target_i (pred_target),
    .req           (req_if.seq)
  );

  fetch_queue #(
    .DEPTH (DEPTH)
  ) fetch_queue_i (
    .clk_i (clk),
    .rst_i (rst),
    .req   (req_if.queue),
    .head  (head_if.queue)
  );

  fetch_issue fetch_issue_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .freeze_i    (exu_freeze_i),
    .br_miss_i   (exu_br_miss_i),
    .head        (head_if.issue),
    .vld_o       (ifu_vld_o),
    .inst_o      (ifu_inst_o),
    .pc_o        (ifu_pc_o),
    .order_o     (ifu_order_o),
    .br_taken_o  (ifu_br_taken_o),
    .pred_next_o (ifu_pred_next_o),
    .class_o     (ifu_class_o)
  );

endmodule

//--- fetch_queue_asserts.sv
`timescale 1ns/1ps

module fetch_queue_asserts #(
  parameter int DEPTH = fetch_pkg::DEPTH_DEFAULT
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       wr_i,
  input  logic                       full_i,
  input  logic                       flush_i,
  input  logic                       pop_i,
  input  logic                       ready_i,
  input  logic [$clog2(DEPTH+1)-1:0] count_i
);

  // Failures so far, polled from the testbench every cycle
  int fail_count = 0;

  wr_not_full_a : assert property (@(posedge clk_i) disable iff (rst_i)
    !(wr_i && full_i && !flush_i))
  else
  begin
    fail_count++;
    $error("metadata write into a full queue");
  end

  pop_needs_ready_a : assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> ready_i)
  else
  begin
    fail_count++;
    $error("pop while the head entry is not ready");
  end

  count_bound_a : assert property (@(posedge clk_i) disable iff (rst_i)
    count_i <= DEPTH)
  else
  begin
    fail_count++;
    $error("queue entry count above depth");
  end

endmodule

bind fetch_queue fetch_queue_asserts #(
  .DEPTH (DEPTH)
) queue_asserts_i (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .wr_i    (req.wr),
  .full_i  (req.full),
  .flush_i (req.flush),
  .pop_i   (head.pop),
  .ready_i (head.ready),
  .count_i (count)
);

//--- fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb;

  localparam int XLEN         = fetch_pkg::XLEN;
  localparam int DEPTH        = fetch_pkg::DEPTH_DEFAULT;
  localparam int BTB_N        = fetch_pkg::BTB_ENTRIES_DEFAULT;
  localparam int BTB_IW       = $clog2(BTB_N);
  localparam int CLK_NS       = 40;
  localparam int RESET_CYCLES = 10;
  localparam int N_ISSUE      = 500;
  // Cycles per instruction with stall bursts, freeze bursts and stale responses
  localparam int WORST_LAT    = 60;
  localparam int MARGIN       = 200;
  localparam int WATCHDOG_NS  = (N_ISSUE * WORST_LAT + RESET_CYCLES + MARGIN) * CLK_NS;
  localparam int MIN_MISS_GAP = 40;
  localparam logic [XLEN-1:0] REGION = 32'h0000_3ffc;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     order;
    logic            taken;
    logic [XLEN-1:0] next;
  } entry_t;

  logic                     clk;
  logic                     rst;
  logic                     br_miss;
  logic [XLEN-1:0]          br_pc;
  logic                     br_taken;
  logic [XLEN-1:0]          pc_next;
  logic [31:0]              order_next;
  logic                     freeze;
  logic [XLEN-1:0]          bus_adr;
  logic                     bus_stb;
  logic [3:0]               bus_tgc;
  logic                     bus_stall;
  logic                     bus_ack;
  logic [XLEN-1:0]          bus_data;
  logic [3:0]               bus_rtgc;
  logic                     ifu_vld;
  logic [XLEN-1:0]          ifu_inst;
  logic [XLEN-1:0]          ifu_pc;
  logic [31:0]              ifu_order;
  logic                     ifu_taken;
  logic [XLEN-1:0]          ifu_next;
  fetch_pkg::opcode_class_e ifu_class;
  logic [132:0]             issue_outs;

  // Reference model state
  entry_t          mq[$];
  int              n_data;
  logic [XLEN-1:0] m_pc;
  logic [31:0]     m_order;
  logic [3:0]      m_era;
  logic            m_valid[BTB_N];
  logic [XLEN-1:0] m_tag[BTB_N];
  logic [XLEN-1:0] m_target[BTB_N];
  logic            e_vld;
  entry_t          e_ent;
  logic [XLEN-1:0] e_inst;

  // Sequence and freeze tracking on the issue side
  logic            new_issue;
  logic            after_miss;
  logic [XLEN-1:0] miss_pc;
  logic [31:0]     miss_order;
  logic [XLEN-1:0] prev_next;
  logic [31:0]     prev_order;
  logic            hold_check;
  logic [132:0]    held_outs;

  // Bus responder and stimulus state
  logic [XLEN-1:0] rsp_adr[$];
  logic [3:0]      rsp_era[$];
  int              idle_left;
  int              stall_left;
  int              freeze_left;
  int              miss_gap;
  logic [31:0]     rng;
  logic            accept;
  int              n_issued;
  int              n_miss;
  int              n_hits;

  assign issue_outs = {ifu_vld, ifu_inst, ifu_pc, ifu_order, ifu_taken, ifu_next, ifu_class};

  fetch_unit #(
    .DEPTH       (DEPTH),
    .BTB_ENTRIES (BTB_N)
  ) fetch_unit_i (
    .clk              (clk),
    .rst              (rst),
    .exu_br_miss_i    (br_miss),
    .exu_br_pc_i      (br_pc),
    .exu_br_taken_i   (br_taken),
    .exu_pc_next_i    (pc_next),
    .exu_order_next_i (order_next),
    .exu_freeze_i     (freeze),
    .bus_adr_o        (bus_adr),
    .bus_stb_o        (bus_stb),
    .bus_tgc_o        (bus_tgc),
    .bus_stall_i      (bus_stall),
    .bus_ack_i        (bus_ack),
    .bus_data_i       (bus_data),
    .bus_tgc_i        (bus_rtgc),
    .ifu_vld_o        (ifu_vld),
    .ifu_inst_o       (ifu_inst),
    .ifu_pc_o         (ifu_pc),
    .ifu_order_o      (ifu_order),
    .ifu_br_taken_o   (ifu_taken),
    .ifu_pred_next_o  (ifu_next),
    .ifu_class_o      (ifu_class)
  );

  always #(CLK_NS / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_next();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Instruction memory, a hash of the address with one of six major opcodes
  function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
    logic [31:0] h;
    logic [6:0]  opc;
    h = addr * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    h = h * 32'h85eb_ca6b;
    h = h ^ (h >> 13);
    case (h % 32'd6)
      32'd0:   opc = 7'b1100011;
      32'd1:   opc = 7'b1101111;
      32'd2:   opc = 7'b1100111;
      32'd3:   opc = 7'b0000011;
      32'd4:   opc = 7'b0100011;
      default: opc = 7'b0110011;
    endcase
    return {h[31:7], opc};
  endfunction

  function automatic fetch_pkg::opcode_class_e class_of(input logic [XLEN-1:0] inst);
    case (inst[6:0])
      7'b1100011: return fetch_pkg::CLS_BRANCH;
      7'b1101111: return fetch_pkg::CLS_JAL;
      7'b1100111: return fetch_pkg::CLS_JALR;
      7'b0000011: return fetch_pkg::CLS_LOAD;
      7'b0100011: return fetch_pkg::CLS_STORE;
      default:    return fetch_pkg::CLS_OTHER;
    endcase
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check(input string name, input logic [135:0] expected,
                       input logic [135:0] actual);
    if (expected !== actual)
      abort_run($sformatf("mismatch %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  task automatic reset_model();
    mq.delete();
    rsp_adr.delete();
    rsp_era.delete();
    n_data = 0;
    m_pc = '0;
    m_order = '0;
    m_era = '0;
    for (int i = 0; i < BTB_N; i++)
      m_valid[i] = 1'b0;
    e_vld = 1'b0;
    new_issue = 1'b0;
    after_miss = 1'b1;
    miss_pc = '0;
    miss_order = '0;
    hold_check = 1'b0;
    idle_left = 0;
    stall_left = 0;
    freeze_left = 0;
    miss_gap = 0;
    n_issued = 0;
    bus_stall <= 1'b0;
    freeze <= 1'b0;
    br_miss <= 1'b0;
    bus_ack <= 1'b0;
  endtask

  // All reads here see the values from before the current edge
  task automatic check_outputs();
    check("bus_stb", mq.size() < DEPTH, bus_stb);
    if (bus_stb)
    begin
      check("bus_adr", m_pc, bus_adr);
      check("bus_tgc", m_era, bus_tgc);
    end
    check("ifu_vld", e_vld, ifu_vld);
    if (e_vld)
    begin
      check("ifu_inst", e_inst, ifu_inst);
      check("ifu_pc", e_ent.pc, ifu_pc);
      check("ifu_order", e_ent.order, ifu_order);
      check("ifu_br_taken", e_ent.taken, ifu_taken);
      check("ifu_pred_next", e_ent.next, ifu_next);
    end
    if (ifu_vld)
      check("ifu_class", class_of(ifu_inst), ifu_class);
    if (new_issue)
    begin
      check("seq_inst", mem_word(ifu_pc), ifu_inst);
      if (after_miss)
      begin
        check("redirect_pc", miss_pc, ifu_pc);
        check("redirect_order", miss_order, ifu_order);
      end
      else
      begin
        check("seq_pc", prev_next, ifu_pc);
        check("seq_order", 32'(prev_order + 1), ifu_order);
      end
      after_miss = 1'b0;
      prev_next = ifu_next;
      prev_order = ifu_order;
    end
    if (hold_check)
      check("freeze_hold", held_outs, issue_outs);
    hold_check = freeze && !br_miss;
    held_outs = issue_outs;
  endtask

  // In-order slave with 0 to 5 idle cycles before each ack
  task automatic respond_bus();
    if (bus_ack)
    begin
      void'(rsp_adr.pop_front());
      void'(rsp_era.pop_front());
    end
    if (accept)
    begin
      rsp_adr.push_back(bus_adr);
      rsp_era.push_back(bus_tgc);
    end
    if (rsp_adr.size() > 0 && idle_left == 0)
    begin
      bus_ack <= 1'b1;
      bus_data <= mem_word(rsp_adr[0]);
      bus_rtgc <= rsp_era[0];
      idle_left = int'(rand_next() % 32'd6);
    end
    else
    begin
      bus_ack <= 1'b0;
      if (rsp_adr.size() > 0)
        idle_left--;
    end
  endtask

  task automatic advance_model();
    entry_t ent;
    logic   pop;
    logic   hit;
    int     idx;
    pop = (n_data > 0) && !freeze && !br_miss;
    if (br_miss)
      e_vld = 1'b0;
    else if (!freeze)
      e_vld = pop;
    new_issue = pop;
    if (pop)
    begin
      e_ent = mq[0];
      e_inst = mem_word(mq[0].pc);
      n_issued++;
      if (mq[0].taken)
        n_hits++;
    end
    // Prediction uses the BTB as it stands before this edge's update
    idx = int'((m_pc >> 2) % BTB_N);
    hit = m_valid[idx] && (m_tag[idx] == (m_pc >> (2 + BTB_IW)));
    ent.pc = m_pc;
    ent.order = m_order;
    ent.taken = hit;
    ent.next = hit ? m_target[idx] : m_pc + 32'd4;
    if (br_miss)
    begin
      mq.delete();
      n_data = 0;
      m_pc = pc_next;
      m_order = order_next;
      m_era = m_era + 1'b1;
      idx = int'((br_pc >> 2) % BTB_N);
      m_valid[idx] = br_taken;
      m_tag[idx] = br_pc >> (2 + BTB_IW);
      m_target[idx] = pc_next;
      after_miss = 1'b1;
      miss_pc = pc_next;
      miss_order = order_next;
      n_miss++;
    end
    else
    begin
      if (pop)
      begin
        void'(mq.pop_front());
        n_data--;
      end
      if (bus_ack && bus_rtgc == m_era)
        n_data++;
      if (accept)
      begin
        mq.push_back(ent);
        m_pc = ent.next;
        m_order++;
      end
    end
  endtask

  task automatic drive_random();
    logic [31:0]     r;
    logic [XLEN-1:0] target;
    r = rand_next();
    if (stall_left > 0)
    begin
      stall_left--;
      bus_stall <= 1'b1;
    end
    else if (r[7:0] < 8'd3)
    begin
      stall_left = 10 + int'(r[15:8] % 8'd20);
      bus_stall <= 1'b1;
    end
    else
      bus_stall <= (r[17:16] == 2'b00);
    r = rand_next();
    if (freeze_left > 0)
    begin
      freeze_left--;
      freeze <= 1'b1;
    end
    else if (r[7:0] < 8'd3)
    begin
      freeze_left = 10 + int'(r[15:8] % 8'd20);
      freeze <= 1'b1;
    end
    else
      freeze <= (r[17:16] == 2'b00);
    r = rand_next();
    miss_gap++;
    if (miss_gap >= MIN_MISS_GAP && r[3:0] == 4'd0)
    begin
      miss_gap = 0;
      target = rand_next() & REGION;
      br_miss <= 1'b1;
      pc_next <= target;
      order_next <= rand_next();
      br_taken <= (r[5:4] != 2'b00);
      // Half the branches sit just past the target, so fetch loops on a BTB hit
      br_pc <= r[6] ? target + {r[9:7], 2'b00} : (rand_next() & REGION);
    end
    else
      br_miss <= 1'b0;
  endtask

  always @(posedge clk)
  begin
    if (rst)
      reset_model();
    else
    begin
      accept = bus_stb && !bus_stall;
      if (fetch_unit_i.fetch_queue_i.queue_asserts_i.fail_count != 0)
        abort_run("a queue assertion failed");
      check_outputs();
      respond_bus();
      advance_model();
      drive_random();
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    br_miss = 1'b0;
    br_pc = '0;
    br_taken = 1'b0;
    pc_next = '0;
    order_next = '0;
    freeze = 1'b0;
    bus_stall = 1'b0;
    bus_ack = 1'b0;
    bus_data = '0;
    bus_rtgc = '0;
    rng = 32'd39231;
    n_miss = 0;
    n_hits = 0;
    n_issued = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    while (n_issued < N_ISSUE)
      @(negedge clk);
    if (n_miss > 0 && n_hits > 0)
    begin
      $display("TESTS PASSED");
      $finish;
    end
    else
      abort_run($sformatf("too few misses (%0d) or predicted-taken issues (%0d)",
                          n_miss, n_hits));
  end

  initial
  begin
    #(WATCHDOG_NS);
    abort_run("timeout, the instruction stream did not finish in time");
  end

endmodule

//--- build.f
fetch_pkg.sv
fetch_req_if.sv
fetch_issue_if.sv
fetch_btb.sv
fetch_sequencer.sv
fetch_queue.sv
fetch_issue.sv
fetch_unit.sv
fetch_queue_asserts.sv
fetch_unit_tb.sv
